//--- src/lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0]  lc3b_word;       // Byte address or data word
    typedef logic [1:0]   lc3b_mem_wmask;  // Bit 0 enables the low byte
    typedef logic [127:0] lc3b_line;       // Eight words, word 0 in the low bits

    // Word request from the processor side, held until its response pulse
    typedef struct packed {
        logic          read;
        logic          write;
        lc3b_mem_wmask wmask;
        lc3b_word      addr;
        lc3b_word      wdata;
    } lc3b_cpu_req_t;

    // Whole-line request toward memory; addr has its low four bits clear
    typedef struct packed {
        logic     read;
        logic     write;
        lc3b_word addr;
        lc3b_line wdata;
    } lc3b_line_req_t;

    typedef enum logic [1:0] {
        cache_idle,
        cache_write_back,  // Data cache only
        cache_fill,
        cache_respond
    } cache_state_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_serve_i,
        arb_serve_d
    } arb_state_e;

    typedef enum logic [1:0] {
        ewb_idle,
        ewb_forward_read,
        ewb_drain
    } ewb_state_e;

    // Picks one 16-bit word out of a line by its word index
    function automatic lc3b_word line_word(input lc3b_line line, input logic [2:0] sel);
        return line[{sel, 4'h0} +: 16];
    endfunction

endpackage : lc3b_types

`default_nettype wire

//--- src/i_cache.sv
`default_nettype none
`timescale 1ns/10ps

module i_cache
    import lc3b_types::*;
#(
    parameter int NUM_SETS = 8
)
(
    input  wire logic           clk,
    input  wire logic           i_arst_n,
    input  wire lc3b_cpu_req_t  i_req,
    output logic                o_resp,
    output lc3b_word            o_rdata,
    output lc3b_line_req_t      o_line_req,
    input  wire logic           i_line_resp,
    input  wire lc3b_line       i_line_rdata
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 12 - IDX_W;  // Address bits above the index

    cache_state_e      state;
    logic [TAG_W-1:0]  tag_mem [NUM_SETS];
    lc3b_line          line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid;

    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic              hit;
    logic              req_new;

    assign idx     = i_req.addr[4 +: IDX_W];
    assign tag     = i_req.addr[15 -: TAG_W];
    assign hit     = valid[idx] && (tag_mem[idx] == tag);
    assign req_new = i_req.read && !o_resp;  // Skip the request still held during our pulse

    // The instruction side only ever reads whole lines
    always_comb begin
        o_line_req       = '0;
        o_line_req.read  = (state == cache_fill);
        o_line_req.addr  = {i_req.addr[15:4], 4'h0};
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= cache_idle;
            valid  <= '0;
            o_resp <= 1'b0;
        end else begin
            o_resp <= 1'b0;
            case (state)
                cache_idle: begin
                    if (req_new && hit) begin
                        o_resp <= 1'b1;
                    end else if (req_new) begin
                        state <= cache_fill;
                    end
                end
                cache_fill: begin
                    if (i_line_resp) begin
                        valid[idx] <= 1'b1;
                        state      <= cache_respond;
                    end
                end
                cache_respond: begin
                    o_resp <= 1'b1;  // Line is installed so answer as a hit would
                    state  <= cache_idle;
                end
                default: state <= cache_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_fill && i_line_resp) begin
            line_mem[idx] <= i_line_rdata;
            tag_mem[idx]  <= tag;
        end
        if ((state == cache_idle && req_new && hit) || state == cache_respond) begin
            o_rdata <= line_word(line_mem[idx], i_req.addr[3:1]);
        end
    end

endmodule : i_cache

`default_nettype wire

//--- src/d_cache.sv
`default_nettype none
`timescale 1ns/10ps

module d_cache
    import lc3b_types::*;
#(
    parameter int NUM_SETS = 8
)
(
    input  wire logic           clk,
    input  wire logic           i_arst_n,
    input  wire lc3b_cpu_req_t  i_req,
    output logic                o_resp,
    output lc3b_word            o_rdata,
    output lc3b_line_req_t      o_line_req,
    input  wire logic           i_line_resp,
    input  wire lc3b_line       i_line_rdata
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 12 - IDX_W;

    cache_state_e        state;
    logic [TAG_W-1:0]    tag_mem [NUM_SETS];
    lc3b_line            line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid;
    logic [NUM_SETS-1:0] dirty;

    logic [IDX_W-1:0]    idx;
    logic [TAG_W-1:0]    tag;
    logic                hit;
    logic                req_new;
    logic                hit_now;     // Hit answered straight from idle
    logic                do_merge;    // Write data goes into the line this cycle
    lc3b_line            merged;

    assign idx     = i_req.addr[4 +: IDX_W];
    assign tag     = i_req.addr[15 -: TAG_W];
    assign hit     = valid[idx] && (tag_mem[idx] == tag);
    assign req_new = (i_req.read || i_req.write) && !o_resp;
    assign hit_now = (state == cache_idle) && req_new && hit;

    // A write miss lands here too, once the fill has allocated the line
    assign do_merge = i_req.write && (hit_now || state == cache_respond);

    always_comb begin
        merged = line_mem[idx];
        if (i_req.wmask[0]) begin
            merged[{i_req.addr[3:1], 4'h0} +: 8] = i_req.wdata[7:0];
        end
        if (i_req.wmask[1]) begin
            merged[{i_req.addr[3:1], 4'h8} +: 8] = i_req.wdata[15:8];
        end
    end

    // Write-back uses the victim's stored tag, the fill uses the requested one
    always_comb begin
        o_line_req.read  = (state == cache_fill);
        o_line_req.write = (state == cache_write_back);
        if (state == cache_write_back) begin
            o_line_req.addr = {tag_mem[idx], idx, 4'h0};
        end else begin
            o_line_req.addr = {i_req.addr[15:4], 4'h0};
        end
        o_line_req.wdata = line_mem[idx];
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= cache_idle;
            valid  <= '0;
            dirty  <= '0;
            o_resp <= 1'b0;
        end else begin
            o_resp <= 1'b0;
            if (do_merge) begin
                dirty[idx] <= 1'b1;
            end
            case (state)
                cache_idle: begin
                    if (hit_now) begin
                        o_resp <= 1'b1;
                    end else if (req_new && valid[idx] && dirty[idx]) begin
                        state <= cache_write_back;  // Old line has to leave first
                    end else if (req_new) begin
                        state <= cache_fill;
                    end
                end
                cache_write_back: begin
                    if (i_line_resp) begin
                        dirty[idx] <= 1'b0;
                        state      <= cache_fill;
                    end
                end
                cache_fill: begin
                    if (i_line_resp) begin
                        valid[idx] <= 1'b1;
                        state      <= cache_respond;
                    end
                end
                cache_respond: begin
                    o_resp <= 1'b1;
                    state  <= cache_idle;
                end
                default: state <= cache_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_fill && i_line_resp) begin
            line_mem[idx] <= i_line_rdata;
            tag_mem[idx]  <= tag;
        end else if (do_merge) begin
            line_mem[idx] <= merged;
        end
        if (hit_now || state == cache_respond) begin
            o_rdata <= line_word(line_mem[idx], i_req.addr[3:1]);
        end
    end

endmodule : d_cache

`default_nettype wire

//--- src/arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module arbiter
    import lc3b_types::*;
(
    input  wire logic            clk,
    input  wire logic            i_arst_n,
    input  wire lc3b_line_req_t  i_i_req,
    input  wire lc3b_line_req_t  i_d_req,
    output logic                 o_i_resp,
    output logic                 o_d_resp,
    output lc3b_line             o_rdata,
    output lc3b_line_req_t       o_mem_req,
    input  wire logic            i_mem_resp,
    input  wire lc3b_line        i_mem_rdata
);

    arb_state_e state;
    logic       i_want;
    logic       d_want;

    assign i_want = i_i_req.read || i_i_req.write;
    assign d_want = i_d_req.read || i_d_req.write;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= arb_idle;
        end else begin
            case (state)
                arb_idle: begin
                    if (d_want) begin
                        state <= arb_serve_d;  // Data side wins a tie
                    end else if (i_want) begin
                        state <= arb_serve_i;
                    end
                end
                arb_serve_i: begin
                    if (i_mem_resp) begin
                        state <= arb_idle;
                    end
                end
                arb_serve_d: begin
                    if (i_mem_resp) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    always_comb begin
        case (state)
            arb_serve_i: o_mem_req = i_i_req;
            arb_serve_d: o_mem_req = i_d_req;
            default:     o_mem_req = '0;  // Nothing goes out while idle
        endcase
    end

    assign o_i_resp = (state == arb_serve_i) && i_mem_resp;
    assign o_d_resp = (state == arb_serve_d) && i_mem_resp;
    assign o_rdata  = i_mem_rdata;  // Only the side that sees a pulse takes it

endmodule : arbiter

`default_nettype wire

//--- src/eviction_write_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module eviction_write_buffer
    import lc3b_types::*;
(
    input  wire logic            clk,
    input  wire logic            i_arst_n,
    input  wire lc3b_line_req_t  i_req,
    output logic                 o_resp,
    output lc3b_line             o_rdata,
    output lc3b_line_req_t       o_pmem_req,
    input  wire logic            i_pmem_resp,
    input  wire lc3b_line        i_pmem_rdata
);

    ewb_state_e state;
    logic       valid;
    lc3b_word   buf_addr;
    lc3b_line   buf_data;

    logic       req_new;
    logic       read_hit;   // Read answered from the held line
    logic       accept_wr;  // Write taken into the empty buffer

    assign req_new   = (i_req.read || i_req.write) && !o_resp;
    assign read_hit  = (state == ewb_idle) && req_new && i_req.read
                       && valid && (buf_addr == i_req.addr);
    assign accept_wr = (state == ewb_idle) && req_new && i_req.write && !valid;

    always_comb begin
        o_pmem_req.read  = (state == ewb_forward_read);
        o_pmem_req.write = (state == ewb_drain);
        o_pmem_req.addr  = (state == ewb_drain) ? buf_addr : i_req.addr;
        o_pmem_req.wdata = buf_data;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= ewb_idle;
            valid  <= 1'b0;
            o_resp <= 1'b0;
        end else begin
            o_resp <= 1'b0;
            case (state)
                ewb_idle: begin
                    if (read_hit || accept_wr) begin
                        o_resp <= 1'b1;
                        valid  <= valid || accept_wr;
                    end else if (req_new && i_req.read) begin
                        state <= ewb_forward_read;  // Reads go ahead of the drain
                    end else if (valid) begin
                        state <= ewb_drain;  // Also frees room for a waiting write
                    end
                end
                ewb_forward_read: begin
                    if (i_pmem_resp) begin
                        o_resp <= 1'b1;
                        state  <= ewb_idle;
                    end
                end
                ewb_drain: begin
                    if (i_pmem_resp) begin
                        valid <= 1'b0;
                        state <= ewb_idle;
                    end
                end
                default: state <= ewb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept_wr) begin
            buf_addr <= i_req.addr;
            buf_data <= i_req.wdata;
        end
        if (read_hit) begin
            o_rdata <= buf_data;
        end else if (state == ewb_forward_read && i_pmem_resp) begin
            o_rdata <= i_pmem_rdata;
        end
    end

endmodule : eviction_write_buffer

`default_nettype wire

//--- src/lc3b_mem_system.sv
`default_nettype none
`timescale 1ns/10ps

module lc3b_mem_system
    import lc3b_types::*;
#(
    parameter int NUM_SETS = 8
)
(
    input  wire logic            clk,
    input  wire logic            i_arst_n,

    // Word ports from the processor
    input  wire lc3b_cpu_req_t   i_ireq,
    output logic                 o_iresp,
    output lc3b_word             o_irdata,
    input  wire lc3b_cpu_req_t   i_dreq,
    output logic                 o_dresp,
    output lc3b_word             o_drdata,

    // Line port to physical memory
    output lc3b_line_req_t       o_pmem_req,
    input  wire logic            i_pmem_resp,
    input  wire lc3b_line        i_pmem_rdata
);

    lc3b_line_req_t i_line_req;
    lc3b_line_req_t d_line_req;
    lc3b_line_req_t arb_mem_req;   // Granted request toward the write buffer
    logic           i_line_resp;
    logic           d_line_resp;
    logic           ewb_resp;
    lc3b_line       arb_rdata;     // Shared by both caches
    lc3b_line       ewb_rdata;

    i_cache #(.NUM_SETS(NUM_SETS)) i_cache (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_ireq),
        .o_resp       (o_iresp),
        .o_rdata      (o_irdata),
        .o_line_req   (i_line_req),
        .i_line_resp  (i_line_resp),
        .i_line_rdata (arb_rdata)
    );

    d_cache #(.NUM_SETS(NUM_SETS)) d_cache (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_dreq),
        .o_resp       (o_dresp),
        .o_rdata      (o_drdata),
        .o_line_req   (d_line_req),
        .i_line_resp  (d_line_resp),
        .i_line_rdata (arb_rdata)
    );

    arbiter arbiter (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_i_req      (i_line_req),
        .i_d_req      (d_line_req),
        .o_i_resp     (i_line_resp),
        .o_d_resp     (d_line_resp),
        .o_rdata      (arb_rdata),
        .o_mem_req    (arb_mem_req),
        .i_mem_resp   (ewb_resp),
        .i_mem_rdata  (ewb_rdata)
    );

    eviction_write_buffer eviction_write_buffer (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_req        (arb_mem_req),
        .o_resp       (ewb_resp),
        .o_rdata      (ewb_rdata),
        .o_pmem_req   (o_pmem_req),
        .i_pmem_resp  (i_pmem_resp),
        .i_pmem_rdata (i_pmem_rdata)
    );

endmodule : lc3b_mem_system

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
)
(
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;  // First rising edge lands half a period in
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- verif/tb_phys_mem.sv
`default_nettype none
`timescale 1ns/10ps

module tb_phys_mem
    import lc3b_types::*;
#(
    parameter int PMEM_LATENCY_MAX = 6
)
(
    input  wire logic            clk,
    input  wire logic            i_arst_n,
    input  wire lc3b_line_req_t  i_req,
    input  wire logic [31:0]     i_rand,   // Fresh random word every cycle
    output logic                 o_resp,
    output lc3b_line             o_rdata
);

    lc3b_line mem [4096];  // One entry per line address, loaded by the testbench
    logic     busy;
    int       count;

    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy    <= 1'b0;
            count   <= 0;
            o_resp  <= 1'b0;
            o_rdata <= '0;
        end else begin
            o_resp <= 1'b0;
            if (!busy) begin
                if ((i_req.read || i_req.write) && !o_resp) begin
                    busy  <= 1'b1;
                    count <= 1 + int'(i_rand % PMEM_LATENCY_MAX);  // Between 1 and the max
                end
            end else if (count > 1) begin
                count <= count - 1;
            end else begin
                busy   <= 1'b0;
                o_resp <= 1'b1;
                if (i_req.write) begin
                    mem[i_req.addr[15:4]] <= i_req.wdata;
                end else begin
                    o_rdata <= mem[i_req.addr[15:4]];
                end
            end
        end
    end

endmodule : tb_phys_mem

`default_nettype wire

//--- verif/lc3b_mem_system_tb.sv
`default_nettype none
`timescale 1ns/10ps

module lc3b_mem_system_tb
    import lc3b_types::*;
();

    localparam int          NUM_SETS         = 8;
    localparam int          PMEM_LATENCY_MAX = 6;
    localparam logic [31:0] SEED             = 32'd56917;
    localparam int          NUM_DIRECTED     = 20;
    localparam int          NUM_ROWS         = 64;
    localparam int          MISS_CYCLES      = 2 * (PMEM_LATENCY_MAX + 6);  // Write-back plus fill
    localparam int          MAX_CYCLES       = NUM_ROWS * 2 * MISS_CYCLES + 10;

    localparam logic [1:0]  PORT_I    = 2'd0;
    localparam logic [1:0]  PORT_D    = 2'd1;
    localparam logic [1:0]  PORT_BOTH = 2'd2;

    typedef struct packed {
        logic [1:0]    port;
        logic          write;  // Data side only
        lc3b_word      iaddr;
        lc3b_word      daddr;
        lc3b_word      wdata;
        lc3b_mem_wmask wmask;
        logic          hit;    // Expect the answer one cycle after sampling
    } row_t;

    logic           clk;
    logic           arst_n;
    lc3b_cpu_req_t  ireq;
    lc3b_cpu_req_t  dreq;
    logic           iresp;
    lc3b_word       irdata;
    logic           dresp;
    lc3b_word       drdata;
    lc3b_line_req_t pmem_req;
    logic           pmem_resp;
    lc3b_line       pmem_rdata;
    logic [31:0]    pmem_rand;
    logic [31:0]    lat_state;
    logic [31:0]    stim_state;
    row_t           rows [NUM_ROWS];
    lc3b_word       shadow [32768];  // Expected memory contents by word address
    int             errors;
    int             cycle_count;

    tb_clock_gen #(.PERIOD_NS(40)) clock_gen (
        .o_clk (clk)
    );

    tb_phys_mem #(.PMEM_LATENCY_MAX(PMEM_LATENCY_MAX)) mem_model (
        .clk      (clk),
        .i_arst_n (arst_n),
        .i_req    (pmem_req),
        .i_rand   (pmem_rand),
        .o_resp   (pmem_resp),
        .o_rdata  (pmem_rdata)
    );

    lc3b_mem_system #(.NUM_SETS(NUM_SETS)) UUT (
        .clk          (clk),
        .i_arst_n     (arst_n),
        .i_ireq       (ireq),
        .o_iresp      (iresp),
        .o_irdata     (irdata),
        .i_dreq       (dreq),
        .o_dresp      (dresp),
        .o_drdata     (drdata),
        .o_pmem_req   (pmem_req),
        .i_pmem_resp  (pmem_resp),
        .i_pmem_rdata (pmem_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Initial word at each byte address
    function automatic lc3b_word fill_word(input lc3b_word addr);
        logic [31:0] x;
        x = xorshift32(SEED ^ {addr, addr});
        return x[31:16] ^ x[15:0];
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("tests failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic load_memories();
        lc3b_line line;
        lc3b_word addr;
        int       l;
        int       w;
        for (l = 0; l < 4096; l++) begin
            for (w = 0; w < 8; w++) begin
                addr               = 16'(l * 16 + w * 2);
                shadow[addr[15:1]] = fill_word(addr);
                line[w * 16 +: 16] = shadow[addr[15:1]];
            end
            mem_model.mem[l] = line;
        end
    endtask

    task automatic write_shadow(input lc3b_word addr, input lc3b_word data,
                                input lc3b_mem_wmask mask);
        if (mask[0]) begin
            shadow[addr[15:1]][7:0] = data[7:0];
        end
        if (mask[1]) begin
            shadow[addr[15:1]][15:8] = data[15:8];
        end
    endtask

    task automatic set_row(input int n, input logic [1:0] port, input logic write,
                           input lc3b_word iaddr, input lc3b_word daddr,
                           input lc3b_word wdata, input lc3b_mem_wmask wmask,
                           input logic hit);
        row_t r;
        r.port  = port;
        r.write = write;
        r.iaddr = iaddr;
        r.daddr = daddr;
        r.wdata = wdata;
        r.wmask = wmask;
        r.hit   = hit;
        rows[n] = r;
    endtask

    // Instruction addresses stay below 0x0400 and data above 0x8000, so the two never share a line
    task automatic build_table();
        row_t        r;
        logic [31:0] a;
        logic [31:0] b;
        int          n;
        set_row(0,  PORT_I,    1'b0, 16'h0024, 16'h0000, 16'h0000, 2'b00, 1'b0);
        set_row(1,  PORT_I,    1'b0, 16'h0026, 16'h0000, 16'h0000, 2'b00, 1'b1);
        set_row(2,  PORT_I,    1'b0, 16'h0024, 16'h0000, 16'h0000, 2'b00, 1'b1);
        set_row(3,  PORT_D,    1'b1, 16'h0000, 16'h8000, 16'h1234, 2'b11, 1'b0);
        set_row(4,  PORT_D,    1'b1, 16'h0000, 16'h8002, 16'hab56, 2'b01, 1'b0);
        set_row(5,  PORT_D,    1'b1, 16'h0000, 16'h8004, 16'hcd78, 2'b10, 1'b0);
        set_row(6,  PORT_D,    1'b1, 16'h0000, 16'h8006, 16'hffff, 2'b00, 1'b0);
        set_row(7,  PORT_D,    1'b0, 16'h0000, 16'h8000, 16'h0000, 2'b00, 1'b1);
        set_row(8,  PORT_D,    1'b0, 16'h0000, 16'h8002, 16'h0000, 2'b00, 1'b1);
        set_row(9,  PORT_D,    1'b0, 16'h0000, 16'h8004, 16'h0000, 2'b00, 1'b1);
        set_row(10, PORT_D,    1'b0, 16'h0000, 16'h8006, 16'h0000, 2'b00, 1'b1);
        set_row(11, PORT_D,    1'b1, 16'h0000, 16'h8010, 16'h1111, 2'b11, 1'b0);
        set_row(12, PORT_D,    1'b1, 16'h0000, 16'h8090, 16'h2222, 2'b11, 1'b0);
        set_row(13, PORT_D,    1'b0, 16'h0000, 16'h8010, 16'h0000, 2'b00, 1'b0);
        set_row(14, PORT_D,    1'b0, 16'h0000, 16'h8090, 16'h0000, 2'b00, 1'b0);
        set_row(15, PORT_D,    1'b0, 16'h0000, 16'h8110, 16'h0000, 2'b00, 1'b0);
        set_row(16, PORT_D,    1'b0, 16'h0000, 16'h8012, 16'h0000, 2'b00, 1'b0);
        set_row(17, PORT_BOTH, 1'b0, 16'h0100, 16'h8020, 16'h0000, 2'b00, 1'b0);
        set_row(18, PORT_BOTH, 1'b1, 16'h0102, 16'h8022, 16'h5a5a, 2'b11, 1'b0);
        set_row(19, PORT_BOTH, 1'b0, 16'h0024, 16'h8022, 16'h0000, 2'b00, 1'b0);
        for (n = NUM_DIRECTED; n < NUM_ROWS; n++) begin
            stim_state = xorshift32(stim_state);
            a          = stim_state;
            stim_state = xorshift32(stim_state);
            b          = stim_state;
            r.port     = (a[1:0] == 2'd3) ? PORT_BOTH : a[1:0];
            r.write    = a[2];
            r.wmask    = a[4:3];
            r.iaddr    = {6'b0, a[13:5], 1'b0};
            r.daddr    = {7'b1000000, b[8:1], 1'b0};  // 32 lines, four per set
            r.wdata    = b[31:16];
            r.hit      = 1'b0;
            rows[n]    = r;
        end
    endtask

    // Issues one row and waits for every response it asks for
    task automatic run_row(input row_t r);
        lc3b_cpu_req_t req;
        logic          i_busy;
        logic          d_busy;
        logic          got_i;
        logic          got_d;
        int            cycles;
        i_busy = (r.port != PORT_D);
        d_busy = (r.port != PORT_I);
        cycles = 0;
        @(posedge clk);
        if (i_busy) begin
            req      = '0;
            req.read = 1'b1;
            req.addr = r.iaddr;
            ireq    <= req;
        end
        if (d_busy) begin
            req.read  = !r.write;
            req.write = r.write;
            req.wmask = r.wmask;
            req.addr  = r.daddr;
            req.wdata = r.wdata;
            dreq     <= req;
        end
        while (i_busy || d_busy) begin
            @(negedge clk);
            cycles = cycles + 1;
            got_i  = i_busy && iresp;
            got_d  = d_busy && dresp;
            if (got_i) begin
                check_equal(irdata, shadow[r.iaddr[15:1]], "instruction read data");
            end
            if (got_i && r.hit) begin
                check_equal(cycles, 2, "instruction hit latency");  // Sampled, then pulsed
            end
            if (got_d && r.write) begin
                write_shadow(r.daddr, r.wdata, r.wmask);
            end else if (got_d) begin
                check_equal(drdata, shadow[r.daddr[15:1]], "data read data");
            end
            if (got_d && r.hit) begin
                check_equal(cycles, 2, "data hit latency");
            end
            @(posedge clk);
            if (got_i) begin
                ireq  <= '0;
                i_busy = 1'b0;
            end
            if (got_d) begin
                dreq  <= '0;
                d_busy = 1'b0;
            end
        end
    endtask

    // New random word for the memory model's latency each cycle
    always @(posedge clk) begin
        lat_state  = xorshift32(lat_state);
        pmem_rand <= lat_state;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("tests failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    initial begin
        int n;
        ireq        = '0;
        dreq        = '0;
        arst_n      = 1'b0;
        pmem_rand   = '0;
        lat_state   = SEED;
        stim_state  = SEED;
        errors      = 0;
        cycle_count = 0;
        load_memories();
        build_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_equal(iresp, 1'b0, "instruction response after reset");
        check_equal(dresp, 1'b0, "data response after reset");
        check_equal(pmem_req.read, 1'b0, "memory read level after reset");
        check_equal(pmem_req.write, 1'b0, "memory write level after reset");
        for (n = 0; n < NUM_ROWS; n++) begin
            run_row(rows[n]);
        end
        if (errors == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "Errors were found");
        end
    end

endmodule : lc3b_mem_system_tb

`default_nettype wire

//--- lc3b_mem_system.f
src/lc3b_types.sv
src/i_cache.sv
src/d_cache.sv
src/arbiter.sv
src/eviction_write_buffer.sv
src/lc3b_mem_system.sv
verif/tb_clock_gen.sv
verif/tb_phys_mem.sv
verif/lc3b_mem_system_tb.sv

//--- Bender.yml
package:
  name: lc3b_mem_system

sources:
  - src/lc3b_types.sv
  - src/i_cache.sv
  - src/d_cache.sv
  - src/arbiter.sv
  - src/eviction_write_buffer.sv
  - src/lc3b_mem_system.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_phys_mem.sv
      - verif/lc3b_mem_system_tb.sv
